// ==== verilog/procPkg.sv ====
/* shared types for the
   five stage pipeline */
package procPkg;

	localparam int regAddrW = 3;	// eight registers
	localparam int dataW = 16;	// word and instruction width

	// opcode in instr[15:12], 9..14 unused
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opXor = 4'd3,
		opAddi = 4'd4,
		opLd = 4'd5,
		opSt = 4'd6,
		opBeqz = 4'd7,
		opJ = 4'd8,
		opHalt = 4'd15
	} opT;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluXor = 3'd3,
		aluPassB = 3'd4	// b operand straight through
	} aluOpT;

	// all zero means nop
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluSrcImm;	// b from immediate
		logic branch;
		logic jump;
		logic halt;
		aluOpT aluOp;
		logic useRs;
		logic useRt;
		logic useRdSrc;	// st reads rd as store data
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [dataW-1:0] pc;
		logic [dataW-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic valid;
		logic [dataW-1:0] pc;
		ctrlT ctrl;
		logic [regAddrW-1:0] rd;
		logic [dataW-1:0] opA;
		logic [dataW-1:0] opB;
		logic [dataW-1:0] storeData;
		logic [dataW-1:0] imm;	// sign extended
	} idExT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [regAddrW-1:0] rd;
		logic [dataW-1:0] aluOut;
		logic [dataW-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic halt;
		logic [regAddrW-1:0] rd;
		logic [dataW-1:0] wbData;
	} memWbT;

endpackage

// ==== verilog/pipeReg.sv ====
/* stage latch */
`timescale 1ns/100ps

module pipeReg #(
	parameter type T = logic
) (
	input logic clk,
	input logic arstN,
	input logic hold,	// stall, keep contents
	input logic flush,	// insert bubble, beats hold
	input T d,
	output T q
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			q <= '0;	// bubble
		else if (flush)
			q <= '0;
		else if (!hold)
			q <= d;
	end

endmodule

// ==== verilog/fetch.sv ====
/* fetch stage */
`timescale 1ns/100ps

module fetch #(
	parameter int imemAddrW = 6
) (
	input logic clk,
	input logic arstN,
	input logic imemWrEn,	// load strobe, idle only
	input logic [imemAddrW-1:0] imemAddr,
	input logic [procPkg::dataW-1:0] imemData,
	input logic go,
	input logic stall,
	input logic haltSeen,	// halt sitting in decode
	input logic redirect,
	input logic [procPkg::dataW-1:0] target,
	output procPkg::ifIdT ifId
);

	logic [procPkg::dataW-1:0] imem [2**imemAddrW];
	logic [procPkg::dataW-1:0] pc;
	logic run;
	logic freeze;

	assign freeze = haltSeen && !redirect;	// redirect flushes the halt

	always_ff @(posedge clk) begin
		if (imemWrEn)
			imem[imemAddr] <= imemData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			run <= 1'b0;
		end else if (go) begin
			pc <= '0;	// always start at word 0
			run <= 1'b1;
		end else if (run) begin
			if (redirect)
				pc <= target;
			else if (!stall && !freeze)
				pc <= pc + 1'b1;
			if (freeze)
				run <= 1'b0;	// nothing more after halt
		end
	end

	always_comb begin
		ifId.valid = run && !freeze;
		ifId.pc = pc;
		ifId.instr = imem[pc[imemAddrW-1:0]];	// word addressed, wraps
	end

endmodule

// ==== verilog/control.sv ====
/* opcode decoder */
`timescale 1ns/100ps

module control (
	input logic clk,
	input logic arstN,
	input logic [procPkg::dataW-1:0] instr,
	input logic valid,
	output procPkg::ctrlT ctrl,
	output logic err	// sticky illegal opcode
);

	logic illegal;

	always_comb begin
		ctrl = '0;
		illegal = 1'b0;
		case (procPkg::opT'(instr[15:12]))
			procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
				ctrl.regWrite = 1'b1;
				ctrl.useRs = 1'b1;
				ctrl.useRt = 1'b1;
				ctrl.aluOp = procPkg::aluOpT'({1'b0, instr[13:12]});	// low bits map 1:1
			end
			procPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.useRs = 1'b1;
			end
			procPkg::opLd: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;	// rs + imm6 address
				ctrl.useRs = 1'b1;
			end
			procPkg::opSt: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.useRs = 1'b1;
				ctrl.useRdSrc = 1'b1;	// data comes from rd
			end
			procPkg::opBeqz: begin
				ctrl.branch = 1'b1;
				ctrl.useRs = 1'b1;
				ctrl.aluOp = procPkg::aluPassB;
			end
			procPkg::opJ: ctrl.jump = 1'b1;
			procPkg::opHalt: ctrl.halt = 1'b1;
			default: illegal = 1'b1;	// controls stay zero, acts as bubble
		endcase
		if (!valid)
			ctrl = '0;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			err <= 1'b0;
		else if (valid && illegal)
			err <= 1'b1;
	end

endmodule

// ==== verilog/decode.sv ====
/* decode stage and register file */
`timescale 1ns/100ps

module decode (
	input logic clk,
	input logic arstN,
	input procPkg::ifIdT ifId,
	input procPkg::ctrlT ctrl,
	input logic wrEn,	// from mem/wb
	input logic [procPkg::regAddrW-1:0] wrReg,
	input logic [procPkg::dataW-1:0] wrData,
	output procPkg::idExT idEx,
	output logic [procPkg::regAddrW-1:0] srcA,	// for hazard check
	output logic [procPkg::regAddrW-1:0] srcB
);

	logic [procPkg::dataW-1:0] regs [2**procPkg::regAddrW];
	logic [procPkg::dataW-1:0] readA;
	logic [procPkg::dataW-1:0] readB;
	logic [procPkg::dataW-1:0] imm6Ext;
	logic [procPkg::dataW-1:0] imm12Ext;
	logic [procPkg::regAddrW-1:0] rd;

	assign rd = ifId.instr[11:9];
	assign srcA = ifId.instr[8:6];	// rs
	assign srcB = ctrl.useRdSrc ? rd : ifId.instr[5:3];	// rt, or rd for st

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**procPkg::regAddrW; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrReg] <= wrData;
		end
	end

	// write-through so writeback lands in the same cycle
	assign readA = (wrEn && wrReg == srcA) ? wrData : regs[srcA];
	assign readB = (wrEn && wrReg == srcB) ? wrData : regs[srcB];

	assign imm6Ext = {{(procPkg::dataW-6){ifId.instr[5]}}, ifId.instr[5:0]};
	assign imm12Ext = {{(procPkg::dataW-12){ifId.instr[11]}}, ifId.instr[11:0]};

	always_comb begin
		idEx.valid = ifId.valid;
		idEx.pc = ifId.pc;
		idEx.ctrl = ctrl;
		idEx.rd = rd;
		idEx.opA = readA;
		idEx.opB = readB;
		idEx.storeData = readB;	// only meaningful for st
		idEx.imm = ctrl.jump ? imm12Ext : imm6Ext;
	end

endmodule

// ==== verilog/hazardUnit.sv ====
/* raw stall detection */
`timescale 1ns/100ps

module hazardUnit (
	input logic [procPkg::regAddrW-1:0] srcA,
	input logic [procPkg::regAddrW-1:0] srcB,
	input procPkg::ctrlT ctrl,	// decode stage controls
	input logic ifValid,
	input procPkg::idExT idEx,
	input procPkg::exMemT exMem,
	output logic stall
);

	logic exWrites;
	logic memWrites;
	logic hitA;
	logic hitB;

	// only real, register-writing producers count
	assign exWrites = idEx.valid && idEx.ctrl.regWrite;
	assign memWrites = exMem.valid && exMem.ctrl.regWrite;

	// mem/wb is covered by the regfile bypass
	assign hitA = (exWrites && idEx.rd == srcA) || (memWrites && exMem.rd == srcA);
	assign hitB = (exWrites && idEx.rd == srcB) || (memWrites && exMem.rd == srcB);

	assign stall = ifValid &&
		((ctrl.useRs && hitA) || ((ctrl.useRt || ctrl.useRdSrc) && hitB));

endmodule

// ==== verilog/execute.sv ====
/* execute stage */
`timescale 1ns/100ps

module execute (
	input procPkg::idExT idEx,
	output procPkg::exMemT exMem,
	output logic redirect,	// taken beqz or j
	output logic [procPkg::dataW-1:0] target
);

	logic [procPkg::dataW-1:0] aluB;
	logic [procPkg::dataW-1:0] aluOut;
	logic taken;

	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			procPkg::aluAdd: aluOut = idEx.opA + aluB;	// also ld/st address
			procPkg::aluSub: aluOut = idEx.opA - aluB;
			procPkg::aluAnd: aluOut = idEx.opA & aluB;
			procPkg::aluXor: aluOut = idEx.opA ^ aluB;
			procPkg::aluPassB: aluOut = aluB;
			default: aluOut = '0;
		endcase
	end

	// beqz tests rs only
	assign taken = idEx.ctrl.branch && idEx.opA == '0;
	assign redirect = idEx.valid && (taken || idEx.ctrl.jump);

	// imm already holds imm6 or imm12 per decode
	assign target = idEx.pc + 1'b1 + idEx.imm;

	always_comb begin
		exMem.valid = idEx.valid;
		exMem.ctrl = idEx.ctrl;
		exMem.rd = idEx.rd;
		exMem.aluOut = aluOut;
		exMem.storeData = idEx.storeData;
	end

endmodule

// ==== verilog/memory.sv ====
/* data memory and writeback select */
`timescale 1ns/100ps

module memory #(
	parameter int dmemAddrW = 6
) (
	input logic clk,
	input logic arstN,
	input procPkg::exMemT exMem,
	output procPkg::memWbT memWb
);

	logic [procPkg::dataW-1:0] dmem [2**dmemAddrW];
	logic [dmemAddrW-1:0] addr;
	logic [procPkg::dataW-1:0] rdData;

	assign addr = exMem.aluOut[dmemAddrW-1:0];	// upper address bits ignored
	assign rdData = dmem[addr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**dmemAddrW; i++)
				dmem[i] <= '0;	// unwritten words read zero
		end else if (exMem.valid && exMem.ctrl.memWrite) begin
			dmem[addr] <= exMem.storeData;
		end
	end

	always_comb begin
		memWb.valid = exMem.valid;
		memWb.regWrite = exMem.ctrl.regWrite;
		memWb.halt = exMem.ctrl.halt;
		memWb.rd = exMem.rd;
		memWb.wbData = exMem.ctrl.memRead ? rdData : exMem.aluOut;
	end

endmodule

// ==== verilog/proc.sv ====
/* pipelined core top */
`timescale 1ns/100ps

module proc #(
	parameter int imemAddrW = 6,
	parameter int dmemAddrW = 6
) (
	input logic clk,
	input logic arstN,
	input logic imemWrEn,
	input logic [imemAddrW-1:0] imemAddr,
	input logic [procPkg::dataW-1:0] imemData,
	input logic go,
	output logic wbEn,	// writeback trace
	output logic [procPkg::regAddrW-1:0] wbReg,
	output logic [procPkg::dataW-1:0] wbData,
	output logic halted,
	output logic err
);

	procPkg::ifIdT ifIdD, ifIdQ;
	procPkg::idExT idExD, idExQ;
	procPkg::exMemT exMemD, exMemQ;
	procPkg::memWbT memWbD, memWbQ;
	procPkg::ctrlT ctrl;	// decode stage controls

	logic stall;
	logic redirect;
	logic haltSeen;
	logic [procPkg::dataW-1:0] target;
	logic [procPkg::regAddrW-1:0] srcA;
	logic [procPkg::regAddrW-1:0] srcB;

	assign haltSeen = ctrl.halt;	// ctrl is zero unless if/id valid

	fetch #(.imemAddrW(imemAddrW)) fetchI (
		.clk(clk), .arstN(arstN),
		.imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
		.go(go), .stall(stall), .haltSeen(haltSeen),
		.redirect(redirect), .target(target),
		.ifId(ifIdD)
	);

	// redirect wins over a stall
	pipeReg #(.T(procPkg::ifIdT)) ifIdReg (
		.clk(clk), .arstN(arstN),
		.hold(stall && !redirect), .flush(redirect),
		.d(ifIdD), .q(ifIdQ)
	);

	control controlI (
		.clk(clk), .arstN(arstN),
		.instr(ifIdQ.instr), .valid(ifIdQ.valid),
		.ctrl(ctrl), .err(err)
	);

	decode decodeI (
		.clk(clk), .arstN(arstN),
		.ifId(ifIdQ), .ctrl(ctrl),
		.wrEn(wbEn), .wrReg(memWbQ.rd), .wrData(memWbQ.wbData),
		.idEx(idExD), .srcA(srcA), .srcB(srcB)
	);

	hazardUnit hazardI (
		.srcA(srcA), .srcB(srcB), .ctrl(ctrl), .ifValid(ifIdQ.valid),
		.idEx(idExQ), .exMem(exMemQ),
		.stall(stall)
	);

	pipeReg #(.T(procPkg::idExT)) idExReg (
		.clk(clk), .arstN(arstN),
		.hold(1'b0), .flush(stall || redirect),	// bubble behind a stall
		.d(idExD), .q(idExQ)
	);

	execute executeI (
		.idEx(idExQ),
		.exMem(exMemD), .redirect(redirect), .target(target)
	);

	pipeReg #(.T(procPkg::exMemT)) exMemReg (
		.clk(clk), .arstN(arstN),
		.hold(1'b0), .flush(1'b0),
		.d(exMemD), .q(exMemQ)
	);

	memory #(.dmemAddrW(dmemAddrW)) memoryI (
		.clk(clk), .arstN(arstN),
		.exMem(exMemQ),
		.memWb(memWbD)
	);

	pipeReg #(.T(procPkg::memWbT)) memWbReg (
		.clk(clk), .arstN(arstN),
		.hold(1'b0), .flush(1'b0),
		.d(memWbD), .q(memWbQ)
	);

	assign wbEn = memWbQ.valid && memWbQ.regWrite;
	assign wbReg = memWbQ.rd;
	assign wbData = memWbQ.wbData;

	// set once halt retires, only reset clears it
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			halted <= 1'b0;
		else if (memWbQ.valid && memWbQ.halt)
			halted <= 1'b1;
	end

endmodule

// ==== verif/clkGen.sv ====
/* testbench clock */
`timescale 1ns/100ps

module clkGen #(
	parameter int periodNs = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;	// even duty cycle
	end

endmodule

// ==== verif/proc_asserts.sv ====
/* core control assertions */
`timescale 1ns/100ps

module procAsserts (
	input logic clk,
	input logic arstN,
	input logic wbEn,
	input logic halted,
	input logic err
);

	// sticky flags, only reset clears them
	haltedSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
		else $error("halted fell without reset");
	errSticky: assert property (@(posedge clk) disable iff (!arstN) err |=> err)
		else $error("err fell without reset");

	noWbWhileHalted: assert property (@(posedge clk) disable iff (!arstN) halted |-> !wbEn)
		else $error("register write seen while halted");

	// all latches hold bubbles right out of reset
	quietAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !wbEn)
		else $error("register write in first cycle after reset");

endmodule

bind proc procAsserts procAssertsI (
	.clk(clk), .arstN(arstN), .wbEn(wbEn), .halted(halted), .err(err)
);

// ==== verif/procTb.sv ====
/* pipelined core testbench */
`timescale 1ns/100ps

module procTb;

	localparam int numTests = 10;
	localparam int periodNs = 40;
	// reset, load, start, worst case run and tail per test
	localparam int cyclesPerTest = 10 + 64 + 4 + 64 * 4 + 8;

	typedef enum int {kAlu, kMem, kBranch, kMix, kIllegal} kindT;
	typedef enum int {cR, cAddi, cLd, cSt, cBeqz, cJ} classT;

	logic clk;
	logic arstN;
	logic imemWrEn;
	logic [5:0] imemAddr;
	logic [procPkg::dataW-1:0] imemData;
	logic go;
	logic wbEn;
	logic [procPkg::regAddrW-1:0] wbReg;
	logic [procPkg::dataW-1:0] wbData;
	logic halted;
	logic err;

	int seed = 32'h5b39382a;
	logic [procPkg::dataW-1:0] prog [64];	// current program image
	logic [procPkg::regAddrW-1:0] expReg [$];	// model write trace
	logic [procPkg::dataW-1:0] expData [$];
	logic expErr;

	clkGen #(.periodNs(periodNs)) clkGenI (.clk(clk));

	proc #(.imemAddrW(6), .dmemAddrW(6)) DUT (
		.clk(clk), .arstN(arstN),
		.imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData), .go(go),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
	);

	task automatic abortRun(string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkWb(string name, logic [procPkg::regAddrW-1:0] wantReg,
		logic [procPkg::dataW-1:0] wantData, logic [procPkg::regAddrW-1:0] gotReg,
		logic [procPkg::dataW-1:0] gotData);
		if (wantReg !== gotReg || wantData !== gotData)
			abortRun($sformatf("ERROR %s: expected r%0d = %h, actual r%0d = %h",
				name, wantReg, wantData, gotReg, gotData));
	endtask

	task automatic checkFlag(string name, logic want, logic got);
		if (want !== got)
			abortRun($sformatf("ERROR %s: expected err = %b, actual err = %b", name, want, got));
	endtask

	function automatic int randBelow(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	function automatic logic [15:0] rType(logic [3:0] op, int rd, int rs, int rt);
		return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
	endfunction

	function automatic logic [15:0] iType(logic [3:0] op, int rd, int rs, int imm);
		return {op, rd[2:0], rs[2:0], imm[5:0]};
	endfunction

	function automatic logic [15:0] pickInstr(kindT kind, int i, int len);
		int roll;
		int regN;
		int maxOff;
		int rd;
		int rs;
		int imm;
		logic afterJump;
		classT cls;
		roll = randBelow(100);
		regN = (kind >= kMix) ? 8 : 4;
		maxOff = (len - 2 - i > 6) ? 6 : len - 2 - i;	// forward, never past halt
		afterJump = (i > 0) && (prog[i-1][15:12] == procPkg::opBeqz ||
			prog[i-1][15:12] == procPkg::opJ);
		// slot behind a branch is decoded even when flushed, keep it legal
		if (kind == kIllegal && !afterJump && randBelow(100) < 12)
			return {4'(9 + randBelow(6)), 12'(randBelow(4096))};
		case (kind)
			kAlu: cls = (roll < 70) ? cR : cAddi;
			kMem: cls = (roll < 30) ? cAddi : (roll < 65) ? cSt : cLd;
			kBranch: cls = (roll < 35) ? cAddi : (roll < 55) ? cR : (roll < 80) ? cBeqz : cJ;
			default: cls = (roll < 30) ? cR : (roll < 45) ? cAddi : (roll < 58) ? cLd :
				(roll < 70) ? cSt : (roll < 85) ? cBeqz : cJ;
		endcase
		rd = randBelow(regN);
		rs = randBelow(regN);
		imm = (kind == kBranch) ? randBelow(3) : randBelow(64);	// small, zeros stay likely
		if (kind == kMem) begin
			rs = (randBelow(4) == 0) ? randBelow(4) : 7;	// r7 never written, shared addresses
			imm = randBelow(16);
		end
		case (cls)
			cR: return rType(4'(randBelow(4)), rd, rs, randBelow(regN));
			cAddi: return iType(procPkg::opAddi, rd, rs, imm);
			cLd: return iType(procPkg::opLd, rd, rs, imm);
			cSt: return iType(procPkg::opSt, rd, rs, imm);
			cBeqz: return iType(procPkg::opBeqz, 0, rs, randBelow(maxOff + 1));
			default: return {procPkg::opJ, 12'(randBelow(maxOff + 1))};
		endcase
	endfunction

	// in-order reference of the instruction set
	task automatic runModel();
		logic [procPkg::dataW-1:0] regs [8];
		logic [procPkg::dataW-1:0] mem [64];
		logic [procPkg::dataW-1:0] pc;
		logic [procPkg::dataW-1:0] ins;
		logic [procPkg::dataW-1:0] imm6;
		logic [procPkg::dataW-1:0] addr;
		logic [procPkg::dataW-1:0] val;
		logic [procPkg::regAddrW-1:0] rd;
		logic [procPkg::regAddrW-1:0] rs;
		logic [procPkg::regAddrW-1:0] rt;
		logic wr;
		logic done;
		expReg.delete();
		expData.delete();
		expErr = 1'b0;
		foreach (regs[k])
			regs[k] = '0;
		foreach (mem[k])
			mem[k] = '0;
		pc = '0;
		done = 1'b0;
		while (!done) begin
			ins = prog[pc[5:0]];
			rd = ins[11:9];
			rs = ins[8:6];
			rt = ins[5:3];
			imm6 = {{10{ins[5]}}, ins[5:0]};
			addr = regs[rs] + imm6;	// also addi result
			pc = pc + 16'd1;
			wr = 1'b1;
			val = '0;
			case (ins[15:12])
				procPkg::opAdd: val = regs[rs] + regs[rt];
				procPkg::opSub: val = regs[rs] - regs[rt];
				procPkg::opAnd: val = regs[rs] & regs[rt];
				procPkg::opXor: val = regs[rs] ^ regs[rt];
				procPkg::opAddi: val = addr;
				procPkg::opLd: val = mem[addr[5:0]];
				default: wr = 1'b0;
			endcase
			case (ins[15:12])
				procPkg::opSt: mem[addr[5:0]] = regs[rd];	// rd is the data source
				procPkg::opBeqz: if (regs[rs] == '0) pc = pc + imm6;
				procPkg::opJ: pc = pc + {{4{ins[11]}}, ins[11:0]};
				procPkg::opHalt: done = 1'b1;
				default: if (ins[15:12] > 4'd8) expErr = 1'b1;	// illegal, no-op otherwise
			endcase
			if (wr) begin
				regs[rd] = val;
				expReg.push_back(rd);
				expData.push_back(val);
			end
		end
	endtask

	task automatic runTest(string name, kindT kind, int len);
		int got;
		logic seenHalt;
		for (int i = 0; i < len - 1; i++)
			prog[i] = pickInstr(kind, i, len);
		prog[len-1] = {procPkg::opHalt, 12'h000};
		runModel();
		@(posedge clk);
		#5 arstN = 1'b0;
		repeat (10) @(posedge clk);
		#5 arstN = 1'b1;
		for (int i = 0; i < len; i++) begin	// one word per strobe
			@(posedge clk);
			#5;
			imemWrEn = 1'b1;
			imemAddr = 6'(i);
			imemData = prog[i];
		end
		@(posedge clk);
		#5;
		imemWrEn = 1'b0;
		go = 1'b1;
		@(posedge clk);
		#5 go = 1'b0;
		got = 0;
		seenHalt = 1'b0;
		while (!seenHalt) begin
			@(negedge clk);	// outputs settled mid cycle
			if (wbEn) begin
				if (got >= expReg.size())
					abortRun($sformatf("test %s wrote r%0d after all %0d expected writes",
						name, wbReg, expReg.size()));
				else begin
					checkWb(name, expReg[got], expData[got], wbReg, wbData);
					got++;
				end
			end
			seenHalt = halted;
		end
		if (got != expReg.size())
			abortRun($sformatf("test %s halted after %0d of %0d expected writes",
				name, got, expReg.size()));
		else begin
			checkFlag(name, expErr, err);
			repeat (8) begin
				@(negedge clk);
				if (wbEn)
					abortRun($sformatf("test %s wrote a register after halting", name));
			end
		end
	endtask

	initial begin
		arstN = 1'b0;
		imemWrEn = 1'b0;
		imemAddr = '0;
		imemData = '0;
		go = 1'b0;
		runTest("aluChain", kAlu, 24);
		runTest("aluChainLong", kAlu, 40);
		runTest("storeLoad", kMem, 30);
		runTest("storeLoadLong", kMem, 50);
		runTest("branchJump", kBranch, 30);
		runTest("branchJumpLong", kBranch, 48);
		runTest("mixedA", kMix, 60);
		runTest("mixedB", kMix, 60);
		runTest("illegalOp", kIllegal, 40);
		runTest("resetReload", kMix, 50);
		$display(">>> PASS");
		$finish;
	end

	// bound on total run time
	initial begin
		#(numTests * cyclesPerTest * periodNs);
		abortRun("processor never halted before the watchdog expired");
	end

endmodule

// ==== list.f ====
verilog/procPkg.sv
verilog/pipeReg.sv
verilog/fetch.sv
verilog/control.sv
verilog/decode.sv
verilog/hazardUnit.sv
verilog/execute.sv
verilog/memory.sv
verilog/proc.sv
verif/clkGen.sv
verif/proc_asserts.sv
verif/procTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module procTb -f list.f -o procSim

out=$(./obj_dir/procSim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qxF -- '>>> PASS'; then
	exit 0
fi
exit 1
